// ==== hist_pkg.sv ====
package hist_pkg;

    // array geometry
    localparam int NUM_BANKS       = 4;
    localparam int PIXELS_PER_BANK = 2;
    localparam int NUM_PIXELS      = NUM_BANKS * PIXELS_PER_BANK;

    // histogram shape
    localparam int BIN_NUM        = 8;
    localparam int COUNT_W        = 5;
    localparam int HITS_PER_HIST  = 64;
    localparam int WORDS_PER_PAGE = PIXELS_PER_BANK * BIN_NUM;

    // derived index widths
    localparam int PIX_W   = $clog2(NUM_PIXELS);
    localparam int BIN_W   = $clog2(BIN_NUM);
    localparam int BANK_W  = $clog2(NUM_BANKS);
    localparam int LPIX_W  = $clog2(PIXELS_PER_BANK);
    localparam int WADDR_W = $clog2(WORDS_PER_PAGE);
    // hit count must reach HITS_PER_HIST itself
    localparam int HCNT_W  = $clog2(HITS_PER_HIST + 1);

    // output word, sized by the wider count view
    localparam int OUT_W     = 1 + LPIX_W + BIN_W + COUNT_W;
    localparam int HDR_PAD_W = OUT_W - 3 - BANK_W;

    typedef logic [COUNT_W-1:0] count_t;

    // incoming hit
    typedef struct packed {
        logic [PIX_W-1:0] pixel;
        logic [BIN_W-1:0] bin;
    } hit_t;

    // hit after bank decode
    typedef struct packed {
        logic [LPIX_W-1:0] local_pixel;
        logic [BIN_W-1:0]  bin;
    } bank_hit_t;

    // clear-on-read request to one bank
    typedef struct packed {
        logic [BANK_W-1:0]  bank;
        logic [WADDR_W-1:0] addr;
        logic               rd;
    } rd_req_t;

    // readout sequencer states
    typedef enum logic [1:0] {
        RO_IDLE,
        RO_SCAN,
        RO_FLUSH
    } ro_state_t;

    typedef struct packed {
        logic                 is_header;
        logic [BANK_W-1:0]    bank;
        logic                 his_num;
        logic                 dropped;
        logic [HDR_PAD_W-1:0] rsvd;
    } hdr_view_t;

    typedef struct packed {
        logic              is_header;
        logic [LPIX_W-1:0] local_pixel;
        logic [BIN_W-1:0]  bin;
        logic [COUNT_W-1:0] count;
    } cnt_view_t;

    // leading is_header bit picks the view
    typedef union packed {
        hdr_view_t hdr;
        cnt_view_t cnt;
    } out_word_u;

endpackage

// ==== hit_router.sv ====
`timescale 1ns/1ps

module hit_router (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           hit_valid,
    input  hist_pkg::hit_t                 hit,
    output logic [hist_pkg::NUM_BANKS-1:0] bank_strobe,
    output hist_pkg::bank_hit_t            bank_hit
);
    import hist_pkg::*;

    logic [BANK_W-1:0] bank_sel;
    logic [LPIX_W-1:0] local_pixel;

    // upper pixel bits pick the bank
    assign bank_sel    = hit.pixel[PIX_W-1:LPIX_W];
    // lower bits address the pixel inside it
    assign local_pixel = hit.pixel[LPIX_W-1:0];

    // one-hot bank strobe, one cycle behind the hit
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bank_strobe <= '0;
        end else if (hit_valid) begin
            bank_strobe <= NUM_BANKS'(1) << bank_sel;
        end else begin
            bank_strobe <= '0;
        end
    end

    // shared payload, only meaningful with a strobe
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            bank_hit.local_pixel <= local_pixel;
            bank_hit.bin         <= hit.bin;
        end
    end

    // at most one bank may count a given hit
    a_strobe_onehot0: assert property (
        @(posedge clk) disable iff (!res)
        $onehot0(bank_strobe)
    ) else $error("bank_strobe not one-hot: %b", bank_strobe);

endmodule

// ==== hist_bank.sv ====
`timescale 1ns/1ps

module hist_bank (
    input  logic                         clk,
    input  logic                         res,
    input  logic [hist_pkg::BANK_W-1:0]  bank_id,
    input  logic                         strobe,
    input  hist_pkg::bank_hit_t          bank_hit,
    input  hist_pkg::rd_req_t            rd_req,
    output logic [hist_pkg::COUNT_W-1:0] rd_data,
    output logic                         page_done,
    output logic                         his_num,
    output logic                         dropped
);
    import hist_pkg::*;

    // two pages of counters, ping-pong
    count_t mem [2][WORDS_PER_PAGE];

    logic               act_page;
    logic               pend;
    logic [HCNT_W-1:0]  hit_cnt;
    logic [WADDR_W-1:0] wr_addr;
    logic               page_full;
    logic               accept;
    logic               last_hit;
    logic               drop;
    logic               rd_hit;
    logic               release_pg;
    logic               swap;

    // pixel is the outer index, bin the inner one
    assign wr_addr = {bank_hit.local_pixel, bank_hit.bin};

    // active page holds all its hits, waiting for a free page
    assign page_full = (hit_cnt == HCNT_W'(HITS_PER_HIST));
    assign accept    = strobe && !page_full;
    assign drop      = strobe && page_full;
    assign last_hit  = accept && (hit_cnt == HCNT_W'(HITS_PER_HIST - 1));

    // readout talks to this bank only
    assign rd_hit     = rd_req.rd && (rd_req.bank == bank_id);
    // last word read frees the finished page
    assign release_pg = rd_hit && (rd_req.addr == WADDR_W'(WORDS_PER_PAGE - 1));

    // swap on the filling hit, or as soon as a blocked page is freed
    assign swap = (last_hit || page_full) && (!pend || release_pg);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            act_page  <= 1'b0;
            pend      <= 1'b0;
            hit_cnt   <= '0;
            page_done <= 1'b0;
            his_num   <= 1'b0;
            dropped   <= 1'b0;
            for (int p = 0; p < 2; p++) begin
                for (int w = 0; w < WORDS_PER_PAGE; w++) begin
                    mem[p][w] <= '0;
                end
            end
        end else begin
            // strobe the cycle after the swap
            page_done <= swap;

            if (swap) begin
                act_page <= ~act_page;
                // finished page number goes out with it
                his_num  <= act_page;
                pend     <= 1'b1;
                hit_cnt  <= '0;
            end else begin
                if (release_pg) begin
                    pend <= 1'b0;
                end
                if (accept) begin
                    hit_cnt <= hit_cnt + 1'b1;
                end
            end

            // sticky until the next header picks it up
            // a drop in the clearing cycle wins
            if (drop) begin
                dropped <= 1'b1;
            end else if (rd_hit && rd_req.addr == '0) begin
                dropped <= 1'b0;
            end

            // saturating increment on the active page
            if (accept && mem[act_page][wr_addr] != '1) begin
                mem[act_page][wr_addr] <= mem[act_page][wr_addr] + 1'b1;
            end

            // clear on read, finished page only
            if (rd_hit) begin
                mem[~act_page][rd_req.addr] <= '0;
            end
        end
    end

    // read data one cycle after the request
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            rd_data <= mem[~act_page][rd_req.addr];
        end
    end

    // readout may only touch a finished page, never the one counting
    a_rd_finished_only: assert property (
        @(posedge clk) disable iff (!res)
        rd_hit |-> pend
    ) else $error("bank %0d read while no page pending", bank_id);

    a_hit_cnt_max: assert property (
        @(posedge clk) disable iff (!res)
        hit_cnt <= HCNT_W'(HITS_PER_HIST)
    ) else $error("bank %0d hit count overflow: %0d", bank_id, hit_cnt);

endmodule

// ==== hist_readout.sv ====
`timescale 1ns/1ps

module hist_readout (
    input  logic                                        clk,
    input  logic                                        res,
    input  logic [hist_pkg::NUM_BANKS-1:0]              page_done,
    input  logic [hist_pkg::NUM_BANKS-1:0]              his_num,
    input  logic [hist_pkg::NUM_BANKS-1:0]              dropped,
    input  hist_pkg::count_t [hist_pkg::NUM_BANKS-1:0]  rd_data,
    output hist_pkg::rd_req_t                           rd_req,
    output logic                                        out_valid,
    output hist_pkg::out_word_u                         out_word
);
    import hist_pkg::*;

    ro_state_t          state;
    logic [NUM_BANKS-1:0] pending;
    logic [NUM_BANKS-1:0] done_clr;
    logic [BANK_W-1:0]  pick;
    logic [BANK_W-1:0]  sel;
    logic [WADDR_W-1:0] addr;
    logic [WADDR_W-1:0] rd_addr_q;
    out_word_u          out_next;

    // lowest pending bank wins
    always_comb begin
        pick = '0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick = BANK_W'(i);
            end
        end
    end

    // header cycle already reads word 0, which also clears dropped in the bank
    always_comb begin
        rd_req = '0;
        case (state)
            RO_IDLE: begin
                rd_req.rd   = |pending;
                rd_req.bank = pick;
                rd_req.addr = '0;
            end
            RO_SCAN: begin
                rd_req.rd   = 1'b1;
                rd_req.bank = sel;
                rd_req.addr = addr;
            end
            default: begin
                rd_req = '0;
            end
        endcase
    end

    // pending bit goes after the last count word
    assign done_clr = (state == RO_FLUSH) ? (NUM_BANKS'(1) << sel) : '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= RO_IDLE;
            pending   <= '0;
            sel       <= '0;
            addr      <= '0;
            out_valid <= 1'b0;
        end else begin
            // new page from the same bank may arrive while flushing
            pending   <= (pending & ~done_clr) | page_done;
            out_valid <= 1'b0;
            case (state)
                RO_IDLE: begin
                    if (|pending) begin
                        sel       <= pick;
                        addr      <= WADDR_W'(1);
                        out_valid <= 1'b1;
                        state     <= RO_SCAN;
                    end
                end
                RO_SCAN: begin
                    out_valid <= 1'b1;
                    addr      <= addr + 1'b1;
                    if (addr == WADDR_W'(WORDS_PER_PAGE - 1)) begin
                        state <= RO_FLUSH;
                    end
                end
                RO_FLUSH: begin
                    // last count word, no more reads
                    out_valid <= 1'b1;
                    state     <= RO_IDLE;
                end
                default: begin
                    state <= RO_IDLE;
                end
            endcase
        end
    end

    // next word: header in idle, else count of the previous read
    always_comb begin
        out_next = '0;
        if (state == RO_IDLE) begin
            out_next.hdr.is_header = 1'b1;
            out_next.hdr.bank      = pick;
            out_next.hdr.his_num   = his_num[pick];
            out_next.hdr.dropped   = dropped[pick];
        end else begin
            out_next.cnt.is_header   = 1'b0;
            out_next.cnt.local_pixel = rd_addr_q[WADDR_W-1 -: LPIX_W];
            out_next.cnt.bin         = rd_addr_q[BIN_W-1:0];
            out_next.cnt.count       = rd_data[sel];
        end
    end

    always_ff @(posedge clk) begin
        // address whose data the bank returns next cycle
        if (rd_req.rd) begin
            rd_addr_q <= rd_req.addr;
        end
        out_word <= out_next;
    end

    // idle with nothing pending emits nothing
    a_no_out_when_idle: assert property (
        @(posedge clk) disable iff (!res)
        (state == RO_IDLE && !(|pending)) |=> !out_valid
    ) else $error("out_valid raised while idle");

endmodule

// ==== hist_top.sv ====
`timescale 1ns/1ps

module hist_top (
    input  logic                clk,
    input  logic                res,
    input  logic                hit_valid,
    input  hist_pkg::hit_t      hit,
    output logic                out_valid,
    output hist_pkg::out_word_u out_word
);
    import hist_pkg::*;

    // router to banks
    logic [NUM_BANKS-1:0] bank_strobe;
    bank_hit_t            bank_hit;

    // banks to readout
    logic [NUM_BANKS-1:0]   page_done;
    logic [NUM_BANKS-1:0]   his_num;
    logic [NUM_BANKS-1:0]   dropped;
    count_t [NUM_BANKS-1:0] rd_data;

    // readout to banks
    rd_req_t rd_req;

    hit_router u_router (
        .clk         (clk),
        .res         (res),
        .hit_valid   (hit_valid),
        .hit         (hit),
        .bank_strobe (bank_strobe),
        .bank_hit    (bank_hit)
    );

    // one bank per group of pixels
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        hist_bank u_bank (
            .clk       (clk),
            .res       (res),
            .bank_id   (BANK_W'(b)),
            .strobe    (bank_strobe[b]),
            .bank_hit  (bank_hit),
            .rd_req    (rd_req),
            .rd_data   (rd_data[b]),
            .page_done (page_done[b]),
            .his_num   (his_num[b]),
            .dropped   (dropped[b])
        );
    end

    hist_readout u_readout (
        .clk       (clk),
        .res       (res),
        .page_done (page_done),
        .his_num   (his_num),
        .dropped   (dropped),
        .rd_data   (rd_data),
        .rd_req    (rd_req),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

endmodule

// ==== tb_hist_top.sv ====
`timescale 1ns/1ps

module tb_hist_top;
    import hist_pkg::*;

    // Galois feedback mask for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    // bank driven in the drop test, served last by the readout
    localparam int BURST_BANK = NUM_BANKS - 1;
    localparam int QUIET_CYCLES = 40;

    logic      clk;
    logic      res;
    logic      hit_valid;
    hit_t      hit;
    logic      out_valid;
    out_word_u out_word;

    // reference histograms of the active page, per bank
    int model_cnt [NUM_BANKS][WORDS_PER_PAGE];
    int model_hits [NUM_BANKS];
    int model_pages [NUM_BANKS];
    // finished model pages, word by word, waiting for the DUT
    int exp_q [NUM_BANKS][$];

    // comparing side
    int recv_pages [NUM_BANKS];
    int last_page [NUM_BANKS][WORDS_PER_PAGE];
    bit exp_his [NUM_BANKS];
    bit loose [NUM_BANKS];
    bit drop_seen;
    bit cur_exact;
    int cur_bank;
    int page_sum;
    int word_idx = WORDS_PER_PAGE;

    int err_cnt;
    int check_cnt;
    int test_cnt;
    int test_fail;
    int test_err0;
    logic [31:0] lfsr;

    hist_top UUT (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .hit       (hit),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // count one accepted hit, saturating, and close the page when full
    function automatic void ref_hit(input int b, input int w);
        if (model_cnt[b][w] < (1 << COUNT_W) - 1) begin
            model_cnt[b][w]++;
        end
        model_hits[b]++;
        if (model_hits[b] == HITS_PER_HIST) begin
            for (int i = 0; i < WORDS_PER_PAGE; i++) begin
                exp_q[b].push_back(model_cnt[b][i]);
                model_cnt[b][i] = 0;
            end
            model_hits[b] = 0;
            model_pages[b]++;
        end
    endfunction

    // header of a clean page
    function automatic out_word_u exp_header(input int b, input bit his);
        out_word_u w;
        w = '0;
        w.hdr.is_header = 1'b1;
        w.hdr.bank      = BANK_W'(b);
        w.hdr.his_num   = his;
        w.hdr.dropped   = 1'b0;
        return w;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            $display("ERROR at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // hit for local word w of bank b, held for one cycle
    task automatic drive_hit(input int b, input int w, input bit modeled);
        hit_valid = 1'b1;
        hit.pixel = PIX_W'(b * PIXELS_PER_BANK + w / BIN_NUM);
        hit.bin   = BIN_W'(w % BIN_NUM);
        if (modeled) begin
            ref_hit(b, w);
        end
        @(posedge clk);
        #1;
        hit_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // fill the rest of the bank's active page, spread over its words
    task automatic complete_page(input int b);
        int n;
        n = (model_hits[b] == 0) ? 0 : HITS_PER_HIST - model_hits[b];
        for (int i = 0; i < n; i++) begin
            drive_hit(b, i % WORDS_PER_PAGE, 1'b1);
            idle(2);
        end
    endtask

    // all model pages read out and the output quiet for a while
    task automatic wait_drain(input string what);
        int quiet;
        int t;
        bit empty;
        quiet = 0;
        t = 0;
        while (quiet < QUIET_CYCLES && t < 4000) begin
            @(posedge clk);
            #1;
            empty = 1'b1;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (exp_q[b].size() != 0) begin
                    empty = 1'b0;
                end
            end
            quiet = (empty && !out_valid) ? quiet + 1 : 0;
            t++;
        end
        if (quiet < QUIET_CYCLES) begin
            $display("readout did not drain within %0d cycles during %s", t, what);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err0) begin
            $display("test %s: passed", name);
        end else begin
            test_fail++;
            $display("test %s: failed with %0d errors", name, err_cnt - test_err0);
        end
        test_err0 = err_cnt;
    endtask

    // output words are stable at the falling edge
    always @(negedge clk) begin
        if (res && out_valid) begin
            if (word_idx == WORDS_PER_PAGE) begin
                check_value("out_word.hdr.is_header", int'(out_word.hdr.is_header), 1);
                cur_bank = int'(out_word.hdr.bank);
                page_sum = 0;
                word_idx = 0;
                if (exp_q[cur_bank].size() >= WORDS_PER_PAGE) begin
                    cur_exact = 1'b1;
                    check_value("out_word (header)", int'(out_word),
                                int'(exp_header(cur_bank, exp_his[cur_bank])));
                end else if (loose[cur_bank]) begin
                    // page from the burst, only its total is known
                    cur_exact = 1'b0;
                    check_value("out_word.hdr.his_num", int'(out_word.hdr.his_num),
                                int'(exp_his[cur_bank]));
                    if (out_word.hdr.dropped) begin
                        drop_seen = 1'b1;
                    end
                end else begin
                    cur_exact = 1'b0;
                    $display("page from bank %0d at time %0t was never filled", cur_bank, $time);
                    err_cnt++;
                end
                exp_his[cur_bank] = !exp_his[cur_bank];
            end else begin
                check_value("out_word.cnt.is_header", int'(out_word.cnt.is_header), 0);
                check_value("out_word.cnt.local_pixel", int'(out_word.cnt.local_pixel),
                            word_idx / BIN_NUM);
                check_value("out_word.cnt.bin", int'(out_word.cnt.bin), word_idx % BIN_NUM);
                last_page[cur_bank][word_idx] = int'(out_word.cnt.count);
                page_sum += int'(out_word.cnt.count);
                if (cur_exact) begin
                    check_value("out_word.cnt.count", int'(out_word.cnt.count),
                                exp_q[cur_bank].pop_front());
                end
                word_idx++;
                if (word_idx == WORDS_PER_PAGE) begin
                    if (!cur_exact) begin
                        check_value("page count sum", page_sum, HITS_PER_HIST);
                    end
                    recv_pages[cur_bank]++;
                end
            end
        end
    end

    initial begin
        int k;
        int n0;
        int i;
        int p0 [NUM_BANKS];
        int mp0 [NUM_BANKS];
        hit_valid = 1'b0;
        hit       = '0;
        res       = 1'b0;
        lfsr      = 32'h79b;
        repeat (10) @(posedge clk);
        #1;
        res = 1'b1;

        // nothing may come out without hits
        for (k = 0; k < 50; k++) begin
            idle(1);
            check_value("out_valid", int'(out_valid), 0);
        end
        end_test("reset state");

        // gaps of at least one cycle keep every page from blocking
        for (i = 0; i < 400; i++) begin
            drive_hit(rand_bits(BANK_W), rand_bits(WADDR_W), 1'b1);
            idle(1 + rand_bits(2));
        end
        wait_drain("slow random hits");
        end_test("slow random hits");

        for (int b = 0; b < NUM_BANKS; b++) begin
            p0[b]  = recv_pages[b];
            mp0[b] = model_pages[b];
            complete_page(b);
            for (i = 0; i < 2 * HITS_PER_HIST; i++) begin
                drive_hit(b, rand_bits(WADDR_W), 1'b1);
                idle(1);
            end
        end
        wait_drain("header and page toggling");
        for (int b = 0; b < NUM_BANKS; b++) begin
            check_value("pages per bank", recv_pages[b] - p0[b], model_pages[b] - mp0[b]);
        end
        end_test("header and page toggling");

        // one word takes the whole page
        complete_page(1);
        for (i = 0; i < HITS_PER_HIST; i++) begin
            drive_hit(1, 5, 1'b1);
            idle(1);
        end
        wait_drain("saturation");
        for (int w = 0; w < WORDS_PER_PAGE; w++) begin
            check_value("saturated page word", last_page[1][w], (w == 5) ? 31 : 0);
        end
        end_test("saturation");

        // two more even pages, the later one reuses the saturated memory
        for (i = 0; i < 2 * HITS_PER_HIST; i++) begin
            drive_hit(1, i % WORDS_PER_PAGE, 1'b1);
            idle(1);
        end
        wait_drain("clear on read");
        for (int w = 0; w < WORDS_PER_PAGE; w++) begin
            check_value("second page word", last_page[1][w], HITS_PER_HIST / WORDS_PER_PAGE);
        end
        end_test("clear on read");

        // every bank one hit short of a full page
        for (int b = 0; b < NUM_BANKS; b++) begin
            complete_page(b);
            for (i = 0; i < HITS_PER_HIST - 1; i++) begin
                drive_hit(b, i % WORDS_PER_PAGE, 1'b1);
                idle(1);
            end
        end
        wait_drain("drop test setup");
        loose[BURST_BANK] = 1'b1;
        drop_seen = 1'b0;
        // four pages queue up, the burst bank is read last
        for (int b = 0; b < NUM_BANKS; b++) begin
            drive_hit(b, WORDS_PER_PAGE - 1, 1'b1);
        end
        for (i = 0; i < 100; i++) begin
            drive_hit(BURST_BANK, i % WORDS_PER_PAGE, 1'b0);
        end
        wait_drain("burst");
        // top up the partial page until it shows up at the output
        n0 = recv_pages[BURST_BANK];
        i = 0;
        while (recv_pages[BURST_BANK] == n0 && i <= HITS_PER_HIST) begin
            drive_hit(BURST_BANK, i % WORDS_PER_PAGE, 1'b0);
            k = 0;
            while (recv_pages[BURST_BANK] == n0 && k < 30) begin
                idle(1);
                k++;
            end
            i++;
        end
        if (recv_pages[BURST_BANK] == n0) begin
            $display("partial page of bank %0d never completed after the burst", BURST_BANK);
            err_cnt++;
        end
        wait_drain("burst recovery");
        loose[BURST_BANK] = 1'b0;
        check_value("dropped flag seen", int'(drop_seen), 1);
        // model of this bank is empty again
        for (i = 0; i < HITS_PER_HIST; i++) begin
            drive_hit(BURST_BANK, rand_bits(WADDR_W), 1'b1);
            idle(1);
        end
        wait_drain("page after the burst");
        end_test("drop and recovery");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hist_pkg.sv
hit_router.sv
hist_bank.sv
hist_readout.sv
hist_top.sv
tb_hist_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_hist_top -f build.f -o sim_hist \
    && ./obj_dir/sim_hist | tee sim.log \
    || { echo "build or run of the simulation broke"; exit 1; }
grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
